// File: Bender.yml
package:
  name: mini_pipe

sources:
  - pipePkg.sv
  - pipeCtrlIf.sv
  - stageRegister.sv
  - regFile.sv
  - decodeUnit.sv
  - executeUnit.sv
  - hazardControl.sv
  - miniPipe.sv
  - target: test
    files:
      - pipe_asserts.sv
      - pipeTb.sv

// File: decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit import pipePkg::*; (
	input logic clk,
	input logic rstN,
	input ifIdT ifId,
	input exWbT wb,
	output idExT idEx
);
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [RegAddrW-1:0] rsF;
	logic [RegAddrW-1:0] rtF;
	logic [RegAddrW-1:0] rdF;
	logic [15:0] imm16;
	logic [XLEN-1:0] immExt;
	logic [XLEN-1:0] rsData;
	logic [XLEN-1:0] rtData;
	aluOpT op;
	logic useImm;
	logic immUpper;
	logic regWrite;
	logic reserved;
	logic [RegAddrW-1:0] dst;

	assign opcode = ifId.instr[31:26];
	assign rsF = ifId.instr[25:21];
	assign rtF = ifId.instr[20:16];
	assign rdF = ifId.instr[15:11];
	assign funct = ifId.instr[5:0];
	assign imm16 = ifId.instr[15:0];

	// lui puts the immediate in the upper half, addiu sign-extends
	assign immExt = immUpper ? {imm16, 16'h0000} : {{(XLEN-16){imm16[15]}}, imm16};

	regFile rf (
		.clk(clk),
		.rstN(rstN),
		.rs(rsF),
		.rt(rtF),
		.rsData(rsData),
		.rtData(rtData),
		.we(wb.valid && wb.regWrite),
		.wAddr(wb.rd),
		.wData(wb.result)
	);

	always_comb begin
		op = AluNone;
		useImm = 1'b0;
		immUpper = 1'b0;
		regWrite = 1'b0;
		reserved = 1'b0;
		dst = rdF;
		case (opcode)
			OpcSpecial: begin
				regWrite = 1'b1;
				case (funct)
					FnAdd: op = AluAdd;
					FnAddu: op = AluAddu;
					FnSubu: op = AluSub;
					FnAnd: op = AluAnd;
					FnOr: op = AluOr;
					FnXor: op = AluXor;
					FnSlt: op = AluSlt;
					default: reserved = 1'b1;
				endcase
			end
			OpcSpecial2: begin
				if (funct == FnMul) begin
					op = AluMul;
					regWrite = 1'b1;
				end else begin
					reserved = 1'b1;
				end
			end
			OpcAddiu: begin
				op = AluAddu;
				useImm = 1'b1;
				regWrite = 1'b1;
				dst = rtF;
			end
			OpcLui: begin
				op = AluLui;
				useImm = 1'b1;
				immUpper = 1'b1;
				regWrite = 1'b1;
				dst = rtF;
			end
			OpcBeq: op = AluBeq;
			OpcBne: op = AluBne;
			default: reserved = 1'b1;
		endcase
	end

	always_comb begin
		idEx = '0;
		idEx.valid = ifId.valid;
		idEx.pc = ifId.pc;
		idEx.aluOp = reserved ? AluNone : op;
		idEx.rs = rsF;
		idEx.rt = rtF;
		idEx.opA = rsData;
		idEx.opB = useImm ? immExt : rtData;
		idEx.useImm = useImm;
		idEx.rd = dst;
		idEx.regWrite = ifId.valid && regWrite && !reserved;
		idEx.branchOff = imm16;
		idEx.exc = ifId.valid && reserved;
		idEx.excCode = reserved ? ExcReserved : ExcNone;
	end

endmodule

// File: executeUnit.sv
`timescale 1ns/1ps

module executeUnit import pipePkg::*; #(
	parameter int MulCycles = 4,
	parameter logic [XLEN-1:0] ExcVector = ExcVectorDefault
) (
	input logic clk,
	input logic rstN,
	input idExT idEx,
	input exWbT exWbQ,
	pipeCtrlIf.exec ctrl,
	output exWbT exWbD,
	output logic [XLEN-1:0] redirectPc,
	output logic excValid,
	output excCodeT excCode,
	output logic [XLEN-1:0] excPc
);
	localparam int CntW = $clog2(MulCycles + 1);

	logic fwdA;
	logic fwdB;
	logic [XLEN-1:0] srcA;
	logic [XLEN-1:0] rtVal;
	logic [XLEN-1:0] srcB;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] target;
	logic ovf;
	logic taken;
	logic excAll;
	logic mulActive;
	logic [CntW-1:0] mulCnt;
	logic [CntW-1:0] remaining;
	logic [XLEN-1:0] mulA;
	logic [XLEN-1:0] mulB;
	logic [XLEN-1:0] mulLow;

	// r0 is never forwarded
	assign fwdA = exWbQ.valid && exWbQ.regWrite && exWbQ.rd != '0 && exWbQ.rd == idEx.rs;
	assign fwdB = exWbQ.valid && exWbQ.regWrite && exWbQ.rd != '0 && exWbQ.rd == idEx.rt;
	assign srcA = fwdA ? exWbQ.result : idEx.opA;
	assign rtVal = fwdB ? exWbQ.result : idEx.opB;
	assign srcB = idEx.useImm ? idEx.opB : rtVal;

	assign sum = srcA + srcB;
	assign ovf = idEx.aluOp == AluAdd && srcA[XLEN-1] == srcB[XLEN-1]
		&& sum[XLEN-1] != srcA[XLEN-1];

	assign taken = (idEx.aluOp == AluBeq && srcA == rtVal)
		|| (idEx.aluOp == AluBne && srcA != rtVal);
	assign target = idEx.pc + XLEN'(4)
		+ {{(XLEN-18){idEx.branchOff[15]}}, idEx.branchOff, 2'b00};

	// Counts down the cycles left while mul sits in execute
	assign mulActive = idEx.valid && idEx.aluOp == AluMul;
	assign remaining = (mulCnt == '0) ? CntW'(MulCycles) : mulCnt;
	assign ctrl.mulBusy = mulActive && remaining > CntW'(1);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			mulCnt <= '0;
		end else if (ctrl.mulBusy) begin
			mulCnt <= remaining - CntW'(1);
		end else begin
			mulCnt <= '0;
		end
	end

	// Operands captured on entry, EX/WB carries bubbles afterwards
	always_ff @(posedge clk) begin
		if (mulActive && mulCnt == '0) begin
			mulA <= srcA;
			mulB <= srcB;
		end
	end

	assign mulLow = (mulCnt == '0) ? srcA * srcB : mulA * mulB;

	always_comb begin
		case (idEx.aluOp)
			AluAdd, AluAddu: result = sum;
			AluSub: result = srcA - srcB;
			AluAnd: result = srcA & srcB;
			AluOr: result = srcA | srcB;
			AluXor: result = srcA ^ srcB;
			AluSlt: result = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			AluLui: result = srcB;
			AluMul: result = mulLow;
			default: result = '0;
		endcase
	end

	assign excAll = idEx.valid && (idEx.exc || ovf);
	assign excValid = excAll;
	assign excPc = idEx.pc;
	assign excCode = !excAll ? ExcNone : (idEx.exc ? idEx.excCode : ExcOverflow);

	assign ctrl.redirect = idEx.valid && (taken || excAll);
	assign redirectPc = excAll ? ExcVector : target;

	always_comb begin
		exWbD.valid = idEx.valid;
		exWbD.rd = idEx.rd;
		exWbD.regWrite = idEx.valid && idEx.regWrite && !excAll;
		exWbD.result = result;
	end

endmodule

// File: hazardControl.sv
`timescale 1ns/1ps

module hazardControl (
	pipeCtrlIf.hazard ctrl
);
	logic holdFront;

	// A redirect squashes the front even if a hold was pending
	assign holdFront = ctrl.mulBusy && !ctrl.redirect;

	always_comb begin
		ctrl.stallFront = holdFront;
		ctrl.flushIfId = ctrl.redirect;
		ctrl.flushIdEx = ctrl.redirect;
		// Execute keeps the mul, so nothing valid follows it yet
		ctrl.bubbleExWb = ctrl.mulBusy;
	end

endmodule

// File: list.f
pipePkg.sv
pipeCtrlIf.sv
stageRegister.sv
regFile.sv
decodeUnit.sv
executeUnit.sv
hazardControl.sv
miniPipe.sv
pipe_asserts.sv
pipeTb.sv

// File: miniPipe.sv
`timescale 1ns/1ps

module miniPipe import pipePkg::*; #(
	parameter int MulCycles = 4,
	parameter logic [XLEN-1:0] ExcVector = ExcVectorDefault
) (
	input logic clk,
	input logic rstN,
	input logic fetchValid,
	input logic [XLEN-1:0] fetchPc,
	input logic [XLEN-1:0] fetchInstr,
	output logic stall,
	output logic redirect,
	output logic [XLEN-1:0] redirectPc,
	output logic wbEn,
	output logic [RegAddrW-1:0] wbRd,
	output logic [XLEN-1:0] wbData,
	output logic excValid,
	output logic [4:0] excCode,
	output logic [XLEN-1:0] excPc
);
	ifIdT ifIdD;
	ifIdT ifIdQ;
	idExT idExD;
	idExT idExQ;
	exWbT exWbD;
	exWbT exWbQ;
	excCodeT excCodeE;

	pipeCtrlIf ctrl ();

	assign ifIdD = '{valid: fetchValid, pc: fetchPc, instr: fetchInstr};

	stageRegister #(.payloadT(ifIdT)) ifIdReg (
		.clk(clk), .rstN(rstN), .wr(!ctrl.stallFront), .flush(ctrl.flushIfId),
		.d(ifIdD), .q(ifIdQ)
	);

	decodeUnit decode (.clk(clk), .rstN(rstN), .ifId(ifIdQ), .wb(exWbQ), .idEx(idExD));

	stageRegister #(.payloadT(idExT)) idExReg (
		.clk(clk), .rstN(rstN), .wr(!ctrl.stallFront), .flush(ctrl.flushIdEx),
		.d(idExD), .q(idExQ)
	);

	executeUnit #(.MulCycles(MulCycles), .ExcVector(ExcVector)) execute (
		.clk(clk),
		.rstN(rstN),
		.idEx(idExQ),
		.exWbQ(exWbQ),
		.ctrl(ctrl.exec),
		.exWbD(exWbD),
		.redirectPc(redirectPc),
		.excValid(excValid),
		.excCode(excCodeE),
		.excPc(excPc)
	);

	stageRegister #(.payloadT(exWbT)) exWbReg (
		.clk(clk), .rstN(rstN), .wr(1'b1), .flush(ctrl.bubbleExWb),
		.d(exWbD), .q(exWbQ)
	);

	hazardControl hazard (.ctrl(ctrl.hazard));

	assign stall = ctrl.stallFront;
	assign redirect = ctrl.redirect;
	assign excCode = excCodeE;

	// r0 writes retire silently
	assign wbEn = exWbQ.valid && exWbQ.regWrite && exWbQ.rd != '0;
	assign wbRd = exWbQ.rd;
	assign wbData = exWbQ.result;

endmodule

// File: pipeCtrlIf.sv
`timescale 1ns/1ps

interface pipeCtrlIf;
	logic mulBusy;
	logic redirect;
	logic stallFront;
	logic flushIfId;
	logic flushIdEx;
	logic bubbleExWb;

	modport hazard (
		input mulBusy,
		input redirect,
		output stallFront,
		output flushIfId,
		output flushIdEx,
		output bubbleExWb
	);

	modport exec (
		output mulBusy,
		output redirect
	);
endinterface

// File: pipePatterns.txt
# I pc instr : fetch stream, squashed words included (hex)
# W rd data : expected writeback, E code pc : expected exception (hex)
I 00400000 24010005
I 00400004 2402fffd
I 00400008 00221821
I 0040000c 00612023
I 00400010 00812824
I 00400014 00a23025
I 00400018 00c13826
I 0040001c 00e1402a
I 00400020 3c091234
I 00400024 70225002
I 00400028 01415821
I 0040002c 10250002
I 00400030 240c0001
I 00400034 240d0001
I 00400038 14250004
I 0040003c 250c7fff
I 00400040 3c0d7fff
I 00400044 01ad7020
I 00400048 240f0001
I 0040004c 240f0002
I bfc00380 00217020
I bfc00384 ffffffff
I bfc00388 240f0003
I bfc0038c 240f0004
I bfc00380 01c97821
I bfc00384 00210021
I bfc00388 000f1821
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffffd
W 05 00000005
W 06 fffffffd
W 07 fffffff8
W 08 00000001
W 09 12340000
W 0a fffffff1
W 0b fffffff6
W 0c 00008000
W 0d 7fff0000
E 0c 00400044
W 0e 0000000a
E 0a bfc00384
W 0f 1234000a
W 03 1234000a

// File: pipePkg.sv
package pipePkg;

	localparam int XLEN = 32;
	localparam int RegAddrW = 5;

	localparam logic [XLEN-1:0] ExcVectorDefault = 32'hbfc00380;

	// Primary opcodes
	localparam logic [5:0] OpcSpecial = 6'h00;
	localparam logic [5:0] OpcSpecial2 = 6'h1c;
	localparam logic [5:0] OpcBeq = 6'h04;
	localparam logic [5:0] OpcBne = 6'h05;
	localparam logic [5:0] OpcAddiu = 6'h09;
	localparam logic [5:0] OpcLui = 6'h0f;

	// SPECIAL and SPECIAL2 function fields
	localparam logic [5:0] FnAdd = 6'h20;
	localparam logic [5:0] FnAddu = 6'h21;
	localparam logic [5:0] FnSubu = 6'h23;
	localparam logic [5:0] FnAnd = 6'h24;
	localparam logic [5:0] FnOr = 6'h25;
	localparam logic [5:0] FnXor = 6'h26;
	localparam logic [5:0] FnSlt = 6'h2a;
	localparam logic [5:0] FnMul = 6'h02;

	typedef enum logic [3:0] {
		AluNone, AluAdd, AluAddu, AluSub, AluAnd, AluOr,
		AluXor, AluSlt, AluLui, AluMul, AluBeq, AluBne
	} aluOpT;

	typedef enum logic [4:0] {
		ExcNone = 5'd0,
		ExcReserved = 5'd10,
		ExcOverflow = 5'd12
	} excCodeT;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
	} ifIdT;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		aluOpT aluOp;
		logic [RegAddrW-1:0] rs;
		logic [RegAddrW-1:0] rt;
		logic [XLEN-1:0] opA;
		logic [XLEN-1:0] opB;
		logic useImm;
		logic [RegAddrW-1:0] rd;
		logic regWrite;
		logic [15:0] branchOff;
		logic exc;
		excCodeT excCode;
	} idExT;

	// Also the forwarding source for execute
	typedef struct packed {
		logic valid;
		logic [RegAddrW-1:0] rd;
		logic regWrite;
		logic [XLEN-1:0] result;
	} exWbT;

endpackage

// File: pipeTb.sv
`timescale 1ns/1ps

module pipeTb import pipePkg::*; ();
	localparam int MulCycles = 4;

	typedef struct packed {
		logic isExc;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
	} eventT;

	logic clk;
	logic rstN;
	logic fetchValid;
	logic [XLEN-1:0] fetchPc;
	logic [XLEN-1:0] fetchInstr;
	logic stall;
	logic redirect;
	logic [XLEN-1:0] redirectPc;
	logic wbEn;
	logic [RegAddrW-1:0] wbRd;
	logic [XLEN-1:0] wbData;
	logic excValid;
	logic [4:0] excCode;
	logic [XLEN-1:0] excPc;

	logic [XLEN-1:0] progPc [$];
	logic [XLEN-1:0] progInstr [$];
	eventT expected [$];
	int errors = 0;
	int cycles = 0;
	int cycleLimit = 0;

	miniPipe #(.MulCycles(MulCycles), .ExcVector(ExcVectorDefault)) u_dut (
		.clk(clk),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchPc(fetchPc),
		.fetchInstr(fetchInstr),
		.stall(stall),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.wbEn(wbEn),
		.wbRd(wbRd),
		.wbData(wbData),
		.excValid(excValid),
		.excCode(excCode),
		.excPc(excPc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic string describe(input eventT ev);
		if (ev.isExc) begin
			return $sformatf("exception code %0d pc %h", ev.a, ev.b);
		end
		return $sformatf("writeback r%0d data %h", ev.a, ev.b);
	endfunction

	task automatic loadPatterns();
		int fd;
		int n;
		byte tag;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		string line;
		fd = $fopen("pipePatterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file pipePatterns.txt");
			errors++;
			return;
		end
		line = "";
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%c %h %h", tag, a, b);
			if (n == 3 && tag == "I") begin
				progPc.push_back(a);
				progInstr.push_back(b);
			end else if (n == 3 && (tag == "W" || tag == "E")) begin
				expected.push_back('{isExc: tag == "E", a: a, b: b});
			end
			line = "";
		end
		$fclose(fd);
		if (progPc.size() == 0 || expected.size() == 0) begin
			$display("The pattern file holds no instructions or no expected events");
			errors++;
		end
	endtask

	// Events come out in program order, a writeback before a younger exception
	task automatic matchEvent(input eventT got);
		eventT head;
		assert (expected.size() > 0) else begin
			errors++;
			$display("Unexpected %s at time %0t, nothing more was expected",
				describe(got), $time);
		end
		if (expected.size() > 0) begin
			head = expected.pop_front();
			assert (head == got) else begin
				errors++;
				$display("Fail at time %0t: got %s, expected %s",
					$time, describe(got), describe(head));
			end
		end
	endtask

	always @(posedge clk) begin
		if (rstN) begin
			if (wbEn) begin
				matchEvent('{isExc: 1'b0, a: XLEN'(wbRd), b: wbData});
			end
			if (excValid) begin
				matchEvent('{isExc: 1'b1, a: XLEN'(excCode), b: excPc});
			end
		end
	end

	task automatic finishRun(input bit timedOut);
		int assertFails;
		assertFails = u_dut.pipeChecks.failures;
		$display("Errors: %0d check failures, %0d assertion failures, %0d events missing",
			errors, assertFails, expected.size());
		if (!timedOut && errors == 0 && assertFails == 0 && expected.size() == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	initial begin
		@(posedge clk);
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the pipeline did not deliver all expected events in %0d cycles",
			cycleLimit);
		finishRun(1'b1);
	end

	initial begin
		int idx;
		bit accepted;
		bit redirected;
		logic [XLEN-1:0] redirectTarget;
		rstN = 1'b0;
		fetchValid = 1'b0;
		fetchPc = '0;
		fetchInstr = '0;
		loadPatterns();
		cycleLimit = progPc.size() * (MulCycles + 3) + 50;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		idx = 0;
		// Fetcher holds its word while stall is high
		while (idx < progPc.size()) begin
			fetchValid = 1'b1;
			fetchPc = progPc[idx];
			fetchInstr = progInstr[idx];
			@(posedge clk);
			accepted = !stall;
			redirected = redirect;
			redirectTarget = redirectPc;
			@(negedge clk);
			if (accepted) begin
				idx++;
			end
			// Stream after the two squashed words starts at the target
			if (redirected && idx < progPc.size()) begin
				assert (redirectTarget == progPc[idx]) else begin
					errors++;
					$display("Fail at time %0t: redirect to %h, the stream continues at %h",
						$time, redirectTarget, progPc[idx]);
				end
			end
		end
		fetchValid = 1'b0;
		fetchPc = '0;
		fetchInstr = '0;
		while (expected.size() > 0) begin
			@(negedge clk);
		end
		// Drain, so stray late events are caught
		repeat (MulCycles + 4) @(negedge clk);
		finishRun(1'b0);
	end

endmodule

// File: pipe_asserts.sv
`timescale 1ns/1ps

module pipeAsserts import pipePkg::*; #(
	parameter int MulCycles = 4
) (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic redirect,
	input logic excValid,
	input logic wbEn,
	input logic [RegAddrW-1:0] wbRd,
	input idExT idExQ
);
	int unsigned failures = 0;
	logic mulInExec;
	logic stallLast;

	assign mulInExec = idExQ.valid && idExQ.aluOp == AluMul;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stallLast <= 1'b0;
		end else begin
			stallLast <= stall;
		end
	end

	excRedirects: assert property (@(posedge clk) disable iff (!rstN) excValid |-> redirect)
		else begin
			failures++;
			$error("Exception raised without a redirect");
		end

	noR0Write: assert property (@(posedge clk) disable iff (!rstN) wbEn |-> wbRd != '0)
		else begin
			failures++;
			$error("Writeback enabled for r0");
		end

	// Entry cycle is the first with mul in execute and no stall before it
	mulStallLength: assert property (@(posedge clk) disable iff (!rstN)
		mulInExec && !stallLast |-> stall [*(MulCycles-1)] ##1 !stall)
		else begin
			failures++;
			$error("Stall length for mul differs from the multiplier latency");
		end

endmodule

bind miniPipe pipeAsserts #(.MulCycles(MulCycles)) pipeChecks (
	.clk(clk),
	.rstN(rstN),
	.stall(stall),
	.redirect(redirect),
	.excValid(excValid),
	.wbEn(wbEn),
	.wbRd(wbRd),
	.idExQ(idExQ)
);

// File: regFile.sv
`timescale 1ns/1ps

module regFile import pipePkg::*; (
	input logic clk,
	input logic rstN,
	input logic [RegAddrW-1:0] rs,
	input logic [RegAddrW-1:0] rt,
	output logic [XLEN-1:0] rsData,
	output logic [XLEN-1:0] rtData,
	input logic we,
	input logic [RegAddrW-1:0] wAddr,
	input logic [XLEN-1:0] wData
);
	localparam int NumRegs = 1 << RegAddrW;

	logic [XLEN-1:0] regs [0:NumRegs-1];

	function automatic logic [XLEN-1:0] readPort(input logic [RegAddrW-1:0] a);
		if (a == '0) begin
			return '0;
		end
		// Same-cycle write wins
		if (we && wAddr == a) begin
			return wData;
		end
		return regs[a];
	endfunction

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wAddr != '0) begin
			regs[wAddr] <= wData;
		end
	end

	always_comb begin
		rsData = readPort(rs);
		rtData = readPort(rt);
	end

endmodule

// File: stageRegister.sv
`timescale 1ns/1ps

module stageRegister #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rstN,
	input logic wr,
	input logic flush,
	input payloadT d,
	output payloadT q
);
	// All-zero payload is an empty slot
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			q <= '0;
		end else if (wr) begin
			q <= d;
		end
	end

endmodule
